// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= IntExecUnitTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0

.PHONY: sim clean

# The run passes only if the pass message shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -F "All tests passed!" > /dev/null

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/IntExecUnitTb.sv ====
`timescale 1ns/1ps

module IntExecUnitTb;
    import ExecPkg::*;

    typedef struct packed {
        IntOp        op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        comp;
        logic        pred;
        logic [31:0] expRes;
        logic        expMisp;
        logic [31:0] expDst;
        ResFlags     expFlags;
    } Row;

    logic clk;
    logic rst;
    logic en;
    logic wbStall;
    logic invalidate;
    logic [SQN_W-1:0] invalidateSqN;
    logic uopValid;
    IntOp opcode;
    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic compressed;
    logic branchPred;
    logic [BRID_W-1:0] branchId;
    logic [TAG_W-1:0] tagDst;
    logic [REG_W-1:0] nmDst;
    logic [SQN_W-1:0] sqN;
    logic wbReq;
    logic [XLEN-1:0] zcFwdResult;
    logic [TAG_W-1:0] zcFwdTag;
    logic zcFwdValid;
    logic resValid;
    logic [XLEN-1:0] resResult;
    logic [TAG_W-1:0] resTagDst;
    logic [REG_W-1:0] resNmDst;
    logic [SQN_W-1:0] resSqN;
    ResFlags resFlags;
    logic resIsBranch;
    logic resBranchTaken;
    logic [BRID_W-1:0] resBranchId;
    logic branchMispredict;
    logic [XLEN-1:0] branchDstPc;
    logic [SQN_W-1:0] branchSqN;
    logic [XLEN-1:0] fetchPc;
    logic predValid;
    logic [XLEN-1:0] predDst;
    logic predIsJump;

    Row rows[$];
    string names[$];
    int errors = 0;
    int checks = 0;
    logic [31:0] lfsr = 32'h6deea772;
    IntOp aluOps[21] = '{intAdd, intSub, intXor, intOr, intAnd, intSll, intSrl, intSra,
                         intSlt, intSltu, intLui, intAndn, intOrn, intXnor, intSh1add,
                         intSh2add, intSh3add, intClz, intCtz, intCpop, intRev8};

    IntExecUnit u_IntExecUnit (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic isCond(input IntOp op);
        return op inside {intBeq, intBne, intBlt, intBge, intBltu, intBgeu};
    endfunction

    function automatic logic [31:0] modelResult(input IntOp op, input logic [31:0] a,
                                                input logic [31:0] b);
        logic [31:0] r;
        logic seen;
        r = '0;
        seen = 1'b0;
        case (op)
            intAdd:    r = a + b;
            intSub:    r = a - b;
            intXor:    r = a ^ b;
            intOr:     r = a | b;
            intAnd:    r = a & b;
            intSll:    r = a << b[4:0];
            intSrl:    r = a >> b[4:0];
            intSra:    r = $signed(a) >>> b[4:0];
            intSlt:    r = {31'b0, $signed(a) < $signed(b)};
            intSltu:   r = {31'b0, a < b};
            intLui:    r = b;
            intAndn:   r = a & ~b;
            intOrn:    r = a | ~b;
            intXnor:   r = ~(a ^ b);
            intSh1add: r = b + {a[30:0], 1'b0};
            intSh2add: r = b + {a[29:0], 2'b0};
            intSh3add: r = b + {a[28:0], 3'b0};
            intClz: begin
                for (int i = 31; i >= 0; i--) begin
                    seen = seen | a[i];
                    if (!seen) begin
                        r = r + 32'd1;
                    end
                end
            end
            intCtz: begin
                for (int i = 0; i < 32; i++) begin
                    seen = seen | a[i];
                    if (!seen) begin
                        r = r + 32'd1;
                    end
                end
            end
            intCpop: begin
                for (int i = 0; i < 32; i++) begin
                    r = r + {31'b0, a[i]};
                end
            end
            intRev8: begin
                for (int k = 0; k < 4; k++) begin
                    r[8*k +: 8] = a[31-8*k -: 8];
                end
            end
            default:   r = '0;
        endcase
        return r;
    endfunction

    task automatic aluRow(input string name, input IntOp op, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] expRes, input ResFlags flags);
        names.push_back(name);
        rows.push_back(Row'{op, a, b, 32'h0, 32'h1000, 1'b0, 1'b0, expRes, 1'b0, 32'h0, flags});
    endtask

    task automatic brRow(input string name, input IntOp op, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] immVal,
                         input logic [31:0] pcVal, input logic comp, input logic pred,
                         input logic [31:0] expRes, input logic expMisp,
                         input logic [31:0] expDst);
        names.push_back(name);
        rows.push_back(Row'{op, a, b, immVal, pcVal, comp, pred, expRes, expMisp, expDst,
                            flagsNone});
    endtask

    task automatic buildTable();
        aluRow("add", intAdd, 32'h12345678, 32'h11111111, 32'h23456789, flagsNone);
        aluRow("sub", intSub, 5, 7, 32'hfffffffe, flagsNone);
        aluRow("xor", intXor, 32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0, flagsNone);
        aluRow("or", intOr, 32'hf0f0f0f0, 32'h0f000000, 32'hfff0f0f0, flagsNone);
        aluRow("and", intAnd, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, flagsNone);
        aluRow("sll", intSll, 32'h11, 32'h23, 32'h88, flagsNone);
        aluRow("srl", intSrl, 32'h80000000, 4, 32'h08000000, flagsNone);
        aluRow("sra", intSra, 32'h80000000, 4, 32'hf8000000, flagsNone);
        aluRow("slt", intSlt, -1, 1, 1, flagsNone);
        aluRow("sltu", intSltu, -1, 1, 0, flagsNone);
        aluRow("lui", intLui, 0, 32'h12345000, 32'h12345000, flagsNone);
        aluRow("andn", intAndn, 32'hff00ff00, 32'h0f0f0f0f, 32'hf000f000, flagsNone);
        aluRow("orn", intOrn, 0, 32'hffff0000, 32'h0000ffff, flagsNone);
        aluRow("xnor", intXnor, 32'hf0f0f0f0, 32'h0ff00ff0, 32'h00ff00ff, flagsNone);
        aluRow("sh1add", intSh1add, 3, 10, 16, flagsNone);
        aluRow("sh2add", intSh2add, 3, 10, 22, flagsNone);
        aluRow("sh3add", intSh3add, 3, 10, 34, flagsNone);
        aluRow("clz zero", intClz, 0, 0, 32, flagsNone);
        aluRow("clz", intClz, 32'h00010000, 0, 15, flagsNone);
        aluRow("ctz zero", intCtz, 0, 0, 32, flagsNone);
        aluRow("ctz", intCtz, 32'h00010000, 0, 16, flagsNone);
        aluRow("cpop", intCpop, 32'hf0f0000f, 0, 12, flagsNone);
        aluRow("rev8", intRev8, 32'h11223344, 0, 32'h44332211, flagsNone);
        aluRow("undefined", intUndefined, 5, 6, 0, flagsExcept);
        brRow("auipc", intAuipc, 0, 0, 32'h2000, 32'h1000, 1'b0, 1'b0, 32'h3000, 1'b0, 0);
        brRow("jal", intJal, 0, 0, 32'h100, 32'h2000, 1'b0, 1'b1, 32'h2004, 1'b0, 32'h2100);
        brRow("jal c", intJal, 0, 0, 32'h100, 32'h2000, 1'b1, 1'b0, 32'h2002, 1'b1, 32'h2100);
        brRow("jalr", intJalr, 32'h3000, 32'h10, 0, 32'h1000, 1'b0, 1'b1, 32'h1004, 1'b1,
              32'h3010);
        brRow("jalr c", intJalr, 32'h3000, -4, 0, 32'h1000, 1'b1, 1'b0, 32'h1002, 1'b1,
              32'h2ffc);
        // Conditional branches, each row also runs with the prediction inverted
        brRow("beq t", intBeq, 5, 5, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b1, 32'h1040);
        brRow("beq n", intBeq, 5, 6, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b0, 32'h1004);
        brRow("bne t neg", intBne, 5, 6, 32'h1ff0, 32'h1000, 1'b0, 1'b0, 0, 1'b1, 32'h0ff0);
        brRow("bne n c", intBne, 5, 5, 32'h40, 32'h1000, 1'b1, 1'b0, 0, 1'b0, 32'h1002);
        brRow("blt t", intBlt, -1, 1, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b1, 32'h1040);
        brRow("blt n", intBlt, 1, -1, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b0, 32'h1004);
        brRow("bge t", intBge, 1, -1, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b1, 32'h1040);
        brRow("bge eq", intBge, 3, 3, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b1, 32'h1040);
        brRow("bge n", intBge, -1, 1, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b0, 32'h1004);
        brRow("bltu t", intBltu, 1, -1, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b1, 32'h1040);
        brRow("bltu n", intBltu, -1, 1, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b0, 32'h1004);
        brRow("bgeu t", intBgeu, -1, 1, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b1, 32'h1040);
        brRow("bgeu n", intBgeu, 1, -1, 32'h40, 32'h1000, 1'b0, 1'b0, 0, 1'b0, 32'h1004);
    endtask

    task automatic checkWord(input string name, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("mismatch %s %s: expected %h, actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic waitForResult(input string name, output logic ok);
        int waitCnt;
        waitCnt = 0;
        while (!resValid && waitCnt < 8) begin
            @(posedge clk);
            #1;
            waitCnt++;
        end
        ok = resValid;
        if (!ok) begin
            $display("%s: no result came out within %0d cycles", name, waitCnt);
            errors++;
        end
    endtask

    task automatic runRow(input int i, input logic flip);
        Row r;
        string name;
        logic cond;
        logic pred;
        logic expMisp;
        logic ok;
        int seq;
        r = rows[i];
        name = flip ? {names[i], " pred inverted"} : names[i];
        cond = isCond(r.op);
        pred = r.pred ^ flip;
        expMisp = r.expMisp ^ flip;
        seq = 2 * i + int'(flip);
        uopValid = 1'b1;
        opcode = r.op;
        srcA = r.a;
        srcB = r.b;
        imm = r.imm;
        pc = r.pc;
        compressed = r.comp;
        branchPred = pred;
        // Side fields change with every op so a stale register shows up
        tagDst = TAG_W'(seq + 1);
        nmDst = REG_W'(seq % 31 + 1);
        branchId = BRID_W'(seq);
        sqN = SQN_W'(seq);
        #10;
        if (!cond) begin
            checkWord(name, "zcFwdResult", r.expRes, zcFwdResult);
        end
        @(posedge clk);
        #1;
        uopValid = 1'b0;
        waitForResult(name, ok);
        if (ok) begin
            if (!cond) begin
                checkWord(name, "resResult", r.expRes, resResult);
            end
            checkWord(name, "resFlags", 32'(r.expFlags), 32'(resFlags));
            checkWord(name, "resTagDst", 32'(tagDst), 32'(resTagDst));
            checkWord(name, "resNmDst", 32'(nmDst), 32'(resNmDst));
            checkWord(name, "resSqN", 32'(sqN), 32'(resSqN));
            checkWord(name, "resBranchId", 32'(branchId), 32'(resBranchId));
            checkWord(name, "branchSqN", 32'(sqN), 32'(branchSqN));
            checkWord(name, "branchMispredict", 32'(expMisp), 32'(branchMispredict));
            checkWord(name, "resIsBranch", 32'(cond), 32'(resIsBranch));
            if (cond || r.op == intJal || r.op == intJalr) begin
                checkWord(name, "branchDstPc", r.expDst, branchDstPc);
            end
            if (cond) begin
                // Taken is the prediction corrected by the mispredict flag
                checkWord(name, "resBranchTaken", 32'(expMisp ^ pred), 32'(resBranchTaken));
            end else if (r.op == intJal || r.op == intJalr) begin
                checkWord(name, "resBranchTaken", 32'd1, 32'(resBranchTaken));
            end
        end
    endtask

    task automatic issueCheck(input string name, input logic expWbReq, input logic expFwd,
                              input logic expValid);
        uopValid = 1'b1;
        opcode = intAdd;
        srcA = 32'd1;
        srcB = 32'd2;
        #10;
        checkWord(name, "wbReq", 32'(expWbReq), 32'(wbReq));
        checkWord(name, "zcFwdValid", 32'(expFwd), 32'(zcFwdValid));
        checkWord(name, "zcFwdTag", 32'(tagDst), 32'(zcFwdTag));
        @(posedge clk);
        #1;
        uopValid = 1'b0;
        checkWord(name, "resValid", 32'(expValid), 32'(resValid));
        if (expValid) begin
            checkWord(name, "resSqN", 32'(sqN), 32'(resSqN));
        end
    endtask

    task automatic checkLookup(input string name, input logic [31:0] pcVal, input logic expHit,
                               input logic [31:0] expDst, input logic expJump);
        fetchPc = pcVal;
        #5;
        checkWord(name, "predValid", 32'(expHit), 32'(predValid));
        if (expHit) begin
            checkWord(name, "predDst", expDst, predDst);
            checkWord(name, "predIsJump", 32'(expJump), 32'(predIsJump));
        end
    endtask

    initial begin
        IntOp op;
        logic [31:0] a;
        logic [31:0] b;
        int tableSize;
        rst = 1'b1;
        en = 1'b1;
        wbStall = 1'b0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        uopValid = 1'b0;
        opcode = intAdd;
        srcA = '0;
        srcB = '0;
        imm = '0;
        pc = '0;
        compressed = 1'b0;
        branchPred = 1'b0;
        branchId = 3'd2;
        tagDst = 7'h15;
        nmDst = 5'd3;
        sqN = '0;
        fetchPc = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        checkLookup("btb after reset", 32'h400a, 1'b0, 0, 1'b0);
        checkLookup("btb after reset", 32'h5010, 1'b0, 0, 1'b0);
        @(posedge clk);
        #1;

        buildTable();
        tableSize = rows.size();
        for (int i = 0; i < tableSize; i++) begin
            runRow(i, 1'b0);
            if (isCond(rows[i].op)) begin
                runRow(i, 1'b1);
            end
        end

        for (int n = 0; n < 40; n++) begin
            op = aluOps[int'(takeBits(5) % 21)];
            a = takeBits(32) >> takeBits(5);
            b = takeBits(32);
            aluRow($sformatf("lfsr %0d %s", n, op.name()), op, a, b, modelResult(op, a, b),
                   flagsNone);
            runRow(rows.size() - 1, 1'b0);
        end

        // Age test wraps at 64
        invalidate = 1'b1;
        invalidateSqN = 6'd10;
        sqN = 6'd11;
        issueCheck("inv younger", 1'b1, 1'b1, 1'b0);
        sqN = 6'd10;
        issueCheck("inv equal", 1'b1, 1'b1, 1'b1);
        sqN = 6'd9;
        issueCheck("inv older", 1'b1, 1'b1, 1'b1);
        invalidateSqN = 6'd62;
        sqN = 6'd1;
        issueCheck("inv wrap younger", 1'b1, 1'b1, 1'b0);
        invalidateSqN = 6'd1;
        sqN = 6'd62;
        issueCheck("inv wrap older", 1'b1, 1'b1, 1'b1);
        invalidate = 1'b0;
        wbStall = 1'b1;
        issueCheck("stall", 1'b1, 1'b1, 1'b0);
        wbStall = 1'b0;
        en = 1'b0;
        issueCheck("disabled", 1'b0, 1'b0, 1'b0);
        en = 1'b1;
        nmDst = 5'd0;
        sqN = 6'd20;
        issueCheck("no dest", 1'b1, 1'b0, 1'b1);
        nmDst = 5'd3;

        brRow("btb beq", intBeq, 7, 7, 32'h80, 32'h4008, 1'b0, 1'b0, 0, 1'b1, 32'h4088);
        runRow(rows.size() - 1, 1'b0);
        @(posedge clk);
        #1;
        checkLookup("btb beq", 32'h400a, 1'b1, 32'h4088, 1'b0);
        brRow("btb jal", intJal, 0, 0, 32'h200, 32'h5010, 1'b1, 1'b0, 32'h5012, 1'b1, 32'h5210);
        runRow(rows.size() - 1, 1'b0);
        @(posedge clk);
        #1;
        checkLookup("btb jal", 32'h5010, 1'b1, 32'h5210, 1'b1);
        brRow("btb predicted", intBgeu, 9, 3, 32'h40, 32'h600c, 1'b0, 1'b1, 0, 1'b0, 32'h604c);
        runRow(rows.size() - 1, 1'b0);
        @(posedge clk);
        #1;
        checkLookup("btb predicted", 32'h600e, 1'b0, 0, 1'b0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== common/ExecPkg.sv ====
package ExecPkg;

    // Data and PC width
    localparam int XLEN = 32;

    localparam int SQN_W = 6;
    localparam int TAG_W = 7;
    localparam int REG_W = 5;
    localparam int BRID_W = 3;

    // Width of a bit count over one XLEN word, 0 to 32 inclusive
    localparam int CNT_W = 6;

    // Direct-mapped BTB, indexed above the halfword bit
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W = 4;
    localparam int BTB_TAG_W = XLEN - BTB_IDX_W - 1;

    typedef enum logic [4:0] {
        intAdd,
        intSub,
        intXor,
        intOr,
        intAnd,
        intSll,
        intSrl,
        intSra,
        intSlt,
        intSltu,
        intLui,
        intAuipc,
        intJal,
        intJalr,
        intBeq,
        intBne,
        intBlt,
        intBge,
        intBltu,
        intBgeu,
        intAndn,
        intOrn,
        intXnor,
        intSh1add,
        intSh2add,
        intSh3add,
        intClz,
        intCtz,
        intCpop,
        intRev8,
        intUndefined
    } IntOp;

    typedef enum logic [1:0] {
        flagsNone,
        flagsExcept
    } ResFlags;

endpackage

// ==== hdl/IntExecUnit.sv ====
`timescale 1ns/1ps

module IntExecUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        en,
    input  logic                        wbStall,
    input  logic                        invalidate,
    input  logic [ExecPkg::SQN_W-1:0]   invalidateSqN,

    input  logic                        uopValid,
    input  ExecPkg::IntOp               opcode,
    input  logic [ExecPkg::XLEN-1:0]    srcA,
    input  logic [ExecPkg::XLEN-1:0]    srcB,
    input  logic [ExecPkg::XLEN-1:0]    imm,
    input  logic [ExecPkg::XLEN-1:0]    pc,
    input  logic                        compressed,
    input  logic                        branchPred,
    input  logic [ExecPkg::BRID_W-1:0]  branchId,
    input  logic [ExecPkg::TAG_W-1:0]   tagDst,
    input  logic [ExecPkg::REG_W-1:0]   nmDst,
    input  logic [ExecPkg::SQN_W-1:0]   sqN,

    output logic                        wbReq,
    output logic [ExecPkg::XLEN-1:0]    zcFwdResult,
    output logic [ExecPkg::TAG_W-1:0]   zcFwdTag,
    output logic                        zcFwdValid,

    output logic                        resValid,
    output logic [ExecPkg::XLEN-1:0]    resResult,
    output logic [ExecPkg::TAG_W-1:0]   resTagDst,
    output logic [ExecPkg::REG_W-1:0]   resNmDst,
    output logic [ExecPkg::SQN_W-1:0]   resSqN,
    output ExecPkg::ResFlags            resFlags,
    output logic                        resIsBranch,
    output logic                        resBranchTaken,
    output logic [ExecPkg::BRID_W-1:0]  resBranchId,

    output logic                        branchMispredict,
    output logic [ExecPkg::XLEN-1:0]    branchDstPc,
    output logic [ExecPkg::SQN_W-1:0]   branchSqN,

    input  logic [ExecPkg::XLEN-1:0]    fetchPc,
    output logic                        predValid,
    output logic [ExecPkg::XLEN-1:0]    predDst,
    output logic                        predIsJump
);
    import ExecPkg::*;

    logic            btUpdValid;
    logic [XLEN-1:0] btUpdSrc;
    logic [XLEN-1:0] btUpdDst;
    logic            btUpdIsJump;

    IntAlu u_alu (
        .clk              (clk),
        .rst              (rst),
        .en               (en),
        .wbStall          (wbStall),
        .invalidate       (invalidate),
        .invalidateSqN    (invalidateSqN),
        .uopValid         (uopValid),
        .opcode           (opcode),
        .srcA             (srcA),
        .srcB             (srcB),
        .imm              (imm),
        .pc               (pc),
        .compressed       (compressed),
        .branchPred       (branchPred),
        .branchId         (branchId),
        .tagDst           (tagDst),
        .nmDst            (nmDst),
        .sqN              (sqN),
        .wbReq            (wbReq),
        .zcFwdResult      (zcFwdResult),
        .zcFwdTag         (zcFwdTag),
        .zcFwdValid       (zcFwdValid),
        .resValid         (resValid),
        .resResult        (resResult),
        .resTagDst        (resTagDst),
        .resNmDst         (resNmDst),
        .resSqN           (resSqN),
        .resFlags         (resFlags),
        .resIsBranch      (resIsBranch),
        .resBranchTaken   (resBranchTaken),
        .resBranchId      (resBranchId),
        .branchMispredict (branchMispredict),
        .branchDstPc      (branchDstPc),
        .branchSqN        (branchSqN),
        .btUpdValid       (btUpdValid),
        .btUpdSrc         (btUpdSrc),
        .btUpdDst         (btUpdDst),
        .btUpdIsJump      (btUpdIsJump)
    );

    BranchTargetBuffer u_btb (
        .clk       (clk),
        .rst       (rst),
        .wrValid   (btUpdValid),
        .wrSrc     (btUpdSrc),
        .wrDst     (btUpdDst),
        .wrIsJump  (btUpdIsJump),
        .lookupPc  (fetchPc),
        .hit       (predValid),
        .hitDst    (predDst),
        .hitIsJump (predIsJump)
    );

endmodule

// ==== hdl/LeadZeroCount.sv ====
`timescale 1ns/1ps

module LeadZeroCount (
    input  logic [ExecPkg::XLEN-1:0]  in,
    output logic [ExecPkg::CNT_W-1:0] out
);
    import ExecPkg::*;

    // Scan upward so the highest set bit is the last one to win
    always_comb begin
        out = CNT_W'(XLEN);
        for (int i = 0; i < XLEN; i++) begin
            if (in[i]) begin
                out = CNT_W'(XLEN - 1 - i);
            end
        end
    end

endmodule

// ==== hdl/PopCount.sv ====
`timescale 1ns/1ps

module PopCount (
    input  logic [ExecPkg::XLEN-1:0]  a,
    output logic [ExecPkg::CNT_W-1:0] res
);
    import ExecPkg::*;

    always_comb begin
        res = '0;
        for (int i = 0; i < XLEN; i++) begin
            res = res + CNT_W'(a[i]);
        end
    end

endmodule

// ==== intAlu/BranchTargetBuffer.sv ====
`timescale 1ns/1ps

module BranchTargetBuffer (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     wrValid,
    input  logic [ExecPkg::XLEN-1:0] wrSrc,
    input  logic [ExecPkg::XLEN-1:0] wrDst,
    input  logic                     wrIsJump,

    input  logic [ExecPkg::XLEN-1:0] lookupPc,
    output logic                     hit,
    output logic [ExecPkg::XLEN-1:0] hitDst,
    output logic                     hitIsJump
);
    import ExecPkg::*;

    logic [BTB_ENTRIES-1:0] entryValid;
    logic [BTB_TAG_W-1:0]   entryTag    [BTB_ENTRIES];
    logic [XLEN-1:0]        entryDst    [BTB_ENTRIES];
    logic                   entryIsJump [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] wrIdx;
    logic [BTB_TAG_W-1:0] wrTag;
    logic [BTB_IDX_W-1:0] rdIdx;
    logic [BTB_TAG_W-1:0] rdTag;

    // Bit 0 is always zero for halfword-aligned PCs
    assign wrIdx = wrSrc[BTB_IDX_W:1];
    assign wrTag = wrSrc[XLEN-1:BTB_IDX_W+1];
    assign rdIdx = lookupPc[BTB_IDX_W:1];
    assign rdTag = lookupPc[XLEN-1:BTB_IDX_W+1];

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (wrValid) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrValid) begin
            entryTag[wrIdx] <= wrTag;
            entryDst[wrIdx] <= wrDst;
            entryIsJump[wrIdx] <= wrIsJump;
        end
    end

    assign hit = entryValid[rdIdx] && (entryTag[rdIdx] == rdTag);
    assign hitDst = entryDst[rdIdx];
    assign hitIsJump = entryIsJump[rdIdx];

endmodule

// ==== intAlu/IntAlu.sv ====
`timescale 1ns/1ps

module IntAlu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        en,
    input  logic                        wbStall,
    input  logic                        invalidate,
    input  logic [ExecPkg::SQN_W-1:0]   invalidateSqN,

    input  logic                        uopValid,
    input  ExecPkg::IntOp               opcode,
    input  logic [ExecPkg::XLEN-1:0]    srcA,
    input  logic [ExecPkg::XLEN-1:0]    srcB,
    input  logic [ExecPkg::XLEN-1:0]    imm,
    input  logic [ExecPkg::XLEN-1:0]    pc,
    input  logic                        compressed,
    input  logic                        branchPred,
    input  logic [ExecPkg::BRID_W-1:0]  branchId,
    input  logic [ExecPkg::TAG_W-1:0]   tagDst,
    input  logic [ExecPkg::REG_W-1:0]   nmDst,
    input  logic [ExecPkg::SQN_W-1:0]   sqN,

    output logic                        wbReq,
    output logic [ExecPkg::XLEN-1:0]    zcFwdResult,
    output logic [ExecPkg::TAG_W-1:0]   zcFwdTag,
    output logic                        zcFwdValid,

    output logic                        resValid,
    output logic [ExecPkg::XLEN-1:0]    resResult,
    output logic [ExecPkg::TAG_W-1:0]   resTagDst,
    output logic [ExecPkg::REG_W-1:0]   resNmDst,
    output logic [ExecPkg::SQN_W-1:0]   resSqN,
    output ExecPkg::ResFlags            resFlags,
    output logic                        resIsBranch,
    output logic                        resBranchTaken,
    output logic [ExecPkg::BRID_W-1:0]  resBranchId,

    output logic                        branchMispredict,
    output logic [ExecPkg::XLEN-1:0]    branchDstPc,
    output logic [ExecPkg::SQN_W-1:0]   branchSqN,

    output logic                        btUpdValid,
    output logic [ExecPkg::XLEN-1:0]    btUpdSrc,
    output logic [ExecPkg::XLEN-1:0]    btUpdDst,
    output logic                        btUpdIsJump
);
    import ExecPkg::*;

    logic [XLEN-1:0]  result;
    ResFlags          flags;
    logic [XLEN-1:0]  srcARev;
    logic [CNT_W-1:0] lzTzCount;
    logic [CNT_W-1:0] popCount;
    logic             lessThan;
    logic             lessThanU;
    logic [XLEN-1:0]  pcPlus2;
    logic [XLEN-1:0]  pcPlus4;
    logic [XLEN-1:0]  nextPc;
    logic             isCondBranch;
    logic             isJal;
    logic             isJalr;
    logic             branchTaken;
    logic [XLEN-1:0]  target;
    logic             mispredict;
    logic             btbWrite;
    logic [SQN_W-1:0] sqDiff;
    logic             accept;

    assign wbReq = uopValid && en;
    assign zcFwdResult = result;
    assign zcFwdTag = tagDst;
    assign zcFwdValid = uopValid && en && (nmDst != '0);

    // ctz is clz of the bit-reversed operand, so one counter serves both
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            srcARev[i] = srcA[XLEN-1-i];
        end
    end

    LeadZeroCount u_lzc (
        .in  (opcode == intClz ? srcA : srcARev),
        .out (lzTzCount)
    );

    PopCount u_popc (
        .a   (srcA),
        .res (popCount)
    );

    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;
    assign pcPlus2 = pc + XLEN'(2);
    assign pcPlus4 = pc + XLEN'(4);
    assign nextPc = compressed ? pcPlus2 : pcPlus4;

    always_comb begin
        flags = flagsNone;
        case (opcode)
            intAdd:    result = srcA + srcB;
            intSub:    result = srcA - srcB;
            intXor:    result = srcA ^ srcB;
            intOr:     result = srcA | srcB;
            intAnd:    result = srcA & srcB;
            intSll:    result = srcA << srcB[4:0];
            intSrl:    result = srcA >> srcB[4:0];
            intSra:    result = $signed(srcA) >>> srcB[4:0];
            intSlt:    result = XLEN'(lessThan);
            intSltu:   result = XLEN'(lessThanU);
            intLui:    result = srcB;
            intAuipc:  result = pc + imm;
            intJal,
            intJalr:   result = nextPc;
            intBeq,
            intBne,
            intBlt,
            intBge,
            intBltu,
            intBgeu:   result = '0;
            intAndn:   result = srcA & ~srcB;
            intOrn:    result = srcA | ~srcB;
            intXnor:   result = srcA ^ ~srcB;
            intSh1add: result = srcB + (srcA << 1);
            intSh2add: result = srcB + (srcA << 2);
            intSh3add: result = srcB + (srcA << 3);
            intClz,
            intCtz:    result = XLEN'(lzTzCount);
            intCpop:   result = XLEN'(popCount);
            intRev8:   result = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            default: begin
                result = '0;
                flags = flagsExcept;
            end
        endcase
    end

    always_comb begin
        case (opcode)
            intJal,
            intJalr: branchTaken = 1'b1;
            intBeq:  branchTaken = srcA == srcB;
            intBne:  branchTaken = srcA != srcB;
            intBlt:  branchTaken = lessThan;
            intBge:  branchTaken = !lessThan;
            intBltu: branchTaken = lessThanU;
            intBgeu: branchTaken = !lessThanU;
            default: branchTaken = 1'b0;
        endcase
    end

    assign isCondBranch = opcode inside {intBeq, intBne, intBlt, intBge, intBltu, intBgeu};
    assign isJal = opcode == intJal;
    assign isJalr = opcode == intJalr;

    always_comb begin
        if (isJalr) begin
            target = srcA + srcB;
        end else if (isJal) begin
            target = pc + imm;
        end else if (isCondBranch && branchTaken) begin
            target = pc + {{(XLEN-13){imm[12]}}, imm[12:0]};
        end else begin
            target = nextPc;
        end
    end

    // Register jumps are never predicted, so they always redirect
    assign mispredict = isJalr || ((isCondBranch || isJal) && (branchTaken != branchPred));
    assign btbWrite = (isCondBranch || isJal) && branchTaken && !branchPred;

    // Wrapping age test against the invalidate point
    assign sqDiff = sqN - invalidateSqN;
    assign accept = uopValid && en && !wbStall && (!invalidate || $signed(sqDiff) <= 0);

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
            branchMispredict <= 1'b0;
            btUpdValid <= 1'b0;
        end else begin
            resValid <= accept;
            branchMispredict <= accept && mispredict;
            btUpdValid <= accept && btbWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resResult <= result;
            resTagDst <= tagDst;
            resNmDst <= nmDst;
            resSqN <= sqN;
            resFlags <= flags;
            resIsBranch <= isCondBranch;
            resBranchTaken <= branchTaken;
            resBranchId <= branchId;
            branchDstPc <= target;
            branchSqN <= sqN;
            // A full-length branch is found by fetch at its second halfword
            btUpdSrc <= compressed ? pc : pcPlus2;
            btUpdDst <= target;
            btUpdIsJump <= isJal;
        end
    end

endmodule

// ==== verilog.f ====
common/ExecPkg.sv
hdl/LeadZeroCount.sv
hdl/PopCount.sv
intAlu/IntAlu.sv
intAlu/BranchTargetBuffer.sv
hdl/IntExecUnit.sv
bench/IntExecUnitTb.sv
